//--- hdl/cdc_fifo_macros.svh
// Compile-time sizes of the dual-clock FIFO, included by the package and by every sizing module.
`ifndef CDC_FIFO_MACROS_SVH
`define CDC_FIFO_MACROS_SVH

// Width of one data word in bits.
`define CDC_FIFO_DATA_WIDTH 16

// Width of a pointer in bits. The array holds 2**width entries.
// The write side needs at least 3 bits to fit its almost-full margin.
`define CDC_FIFO_ADDRESS_WIDTH 4

// Flip-flops in each pointer synchronizer chain.
// Two stages are the usual minimum for metastability settling.
`define CDC_FIFO_SYNC_STAGES 2

// Entries kept free below full when the write side drops ready.
// These cover the words that are still in flight through the write
// pipeline when ready falls, so none of them can overwrite unread data.
`define CDC_FIFO_ALMOST_FULL_MARGIN 4

`endif

//--- hdl/cdc_fifo_pkg.sv
// Shared vector types of the dual-clock FIFO, imported by the interface and the RTL modules.
`include "cdc_fifo_macros.svh"

`default_nettype none

package cdc_fifo_pkg;

    // One data word as it travels through the FIFO.
    // The same type is used on both streams and inside the array.
    typedef logic [`CDC_FIFO_DATA_WIDTH-1:0] cdc_data_t;

    // One array pointer in binary or in Gray code.
    // The pointer wraps naturally at the array depth.
    typedef logic [`CDC_FIFO_ADDRESS_WIDTH-1:0] cdc_pointer_t;

endpackage

`default_nettype wire

//--- hdl/cdc_fifo_write_if.sv
// Write path between the write side and the buffer, all signals in the rx_aclk domain.
`timescale 1ns/100ps
`default_nettype none

interface cdc_fifo_write_if;
    import cdc_fifo_pkg::*;

    logic         write_enable;        // Stores write_data on this edge.
    cdc_data_t    write_data;          // Word to be stored.
    cdc_pointer_t write_pointer;       // Binary address of the next free entry.
    cdc_pointer_t read_pointer_synced; // Read pointer already brought into rx_aclk.

    // The write side owns the word, the enable and the write pointer.
    modport write (
        output write_enable,
        output write_data,
        output write_pointer,
        input  read_pointer_synced
    );

    // The buffer consumes the write and returns the synchronized read pointer.
    modport buffer (
        input  write_enable,
        input  write_data,
        input  write_pointer,
        output read_pointer_synced
    );

endinterface

`default_nettype wire

//--- hdl/cdc_fifo_write.sv
// Write side of the dual-clock FIFO; accepts the rx stream and throttles it before overflow.
`include "cdc_fifo_macros.svh"
`timescale 1ns/100ps
`default_nettype none

module cdc_fifo_write (
    input  logic                    rx_aclk,
    input  logic                    rx_areset_n,
    input  logic                    rx_tvalid,
    input  cdc_fifo_pkg::cdc_data_t rx_tdata,
    output logic                    rx_tready,
    cdc_fifo_write_if.write         write_port
);
    import cdc_fifo_pkg::*;

    localparam int depth = 1 << `CDC_FIFO_ADDRESS_WIDTH; // Entries in the array.

    // Ready drops once this many entries may be occupied.
    localparam cdc_pointer_t almost_full_threshold =
        cdc_pointer_t'(depth - `CDC_FIFO_ALMOST_FULL_MARGIN);

    cdc_pointer_t difference;    // Registered count of entries in use.
    logic         almost_full;   // Difference has reached the threshold.
    logic         ready_allowed; // Set one edge after reset release.

    // The margin does not fit in a pointer narrower than three bits.
    if (`CDC_FIFO_ADDRESS_WIDTH < 3) begin : g_address_width_check
        $error("CDC_FIFO_ADDRESS_WIDTH must be at least 3.");
    end

    // The read pointer lags behind, so this count can only be too high and never too low.
    always_ff @(posedge rx_aclk or negedge rx_areset_n) begin
        if (!rx_areset_n) begin
            difference <= '0;
        end else begin
            difference <= write_port.write_pointer - write_port.read_pointer_synced;
        end
    end

    always_comb begin
        almost_full = (difference >= almost_full_threshold);
    end

    // Holds ready low for one extra edge after reset so the pipeline starts clean.
    always_ff @(posedge rx_aclk or negedge rx_areset_n) begin
        if (!rx_areset_n) begin
            ready_allowed <= 1'b0;
        end else begin
            ready_allowed <= 1'b1;
        end
    end

    always_ff @(posedge rx_aclk or negedge rx_areset_n) begin
        if (!rx_areset_n) begin
            rx_tready <= 1'b0;
        end else begin
            rx_tready <= ready_allowed && !almost_full; // Two edges after release at the earliest.
        end
    end

    // A transfer on this edge becomes an array write on the next one.
    always_ff @(posedge rx_aclk or negedge rx_areset_n) begin
        if (!rx_areset_n) begin
            write_port.write_enable <= 1'b0;
        end else begin
            write_port.write_enable <= rx_tvalid && rx_tready;
        end
    end

    always_ff @(posedge rx_aclk) begin
        write_port.write_data <= rx_tdata; // Only meaningful when write_enable is set.
    end

    // The pointer moves on the same edge that the buffer stores the word.
    always_ff @(posedge rx_aclk or negedge rx_areset_n) begin
        if (!rx_areset_n) begin
            write_port.write_pointer <= '0;
        end else if (write_port.write_enable) begin
            write_port.write_pointer <= write_port.write_pointer + 1'b1;
        end
    end

    // A wrap from all ones to zero would mean the array had silently overflowed.
    difference_no_wrap: assert property (@(posedge rx_aclk) disable iff (!rx_areset_n)
        (difference == '1) |=> (difference != '0))
        else $error("Write difference wrapped from full to empty.");

    // With the margin in place no write can arrive when the count is already at its limit.
    write_not_at_full: assert property (@(posedge rx_aclk) disable iff (!rx_areset_n)
        !(write_port.write_enable && (difference == '1)))
        else $error("Write issued while the FIFO was full.");

endmodule

`default_nettype wire

//--- hdl/cdc_fifo_buffer.sv
// Storage array of the dual-clock FIFO with Gray-coded pointer crossings in both directions.
`include "cdc_fifo_macros.svh"
`timescale 1ns/100ps
`default_nettype none

module cdc_fifo_buffer (
    input  logic                       rx_aclk,
    input  logic                       rx_areset_n,
    input  logic                       tx_aclk,
    input  logic                       tx_areset_n,
    cdc_fifo_write_if.buffer           buffer_port,
    input  cdc_fifo_pkg::cdc_pointer_t read_pointer,
    output cdc_fifo_pkg::cdc_data_t    read_data,
    output cdc_fifo_pkg::cdc_pointer_t write_pointer_synced
);
    import cdc_fifo_pkg::*;

    localparam int depth  = 1 << `CDC_FIFO_ADDRESS_WIDTH;
    localparam int stages = `CDC_FIFO_SYNC_STAGES;

    cdc_data_t    memory [depth];          // Written in rx_aclk, read without a clock.
    cdc_pointer_t write_gray;              // Gray write pointer, rx_aclk domain.
    cdc_pointer_t read_gray;               // Gray read pointer, tx_aclk domain.
    cdc_pointer_t write_gray_sync [stages]; // Write pointer chain clocked by tx_aclk.
    cdc_pointer_t read_gray_sync [stages];  // Read pointer chain clocked by rx_aclk.

    function automatic cdc_pointer_t to_gray(input cdc_pointer_t binary);
        return binary ^ (binary >> 1);
    endfunction

    // Each binary bit is the XOR of all Gray bits from the top down to it.
    function automatic cdc_pointer_t to_binary(input cdc_pointer_t gray);
        cdc_pointer_t binary;
        binary[`CDC_FIFO_ADDRESS_WIDTH-1] = gray[`CDC_FIFO_ADDRESS_WIDTH-1];
        for (int i = `CDC_FIFO_ADDRESS_WIDTH - 2; i >= 0; i--) begin
            binary[i] = binary[i + 1] ^ gray[i];
        end
        return binary;
    endfunction

    always_ff @(posedge rx_aclk) begin
        if (buffer_port.write_enable) begin
            memory[buffer_port.write_pointer] <= buffer_port.write_data;
        end
    end

    always_comb begin
        read_data = memory[read_pointer]; // The read side registers this word itself.
    end

    // The Gray code is registered in its own domain so only one bit toggles per step.
    always_ff @(posedge rx_aclk or negedge rx_areset_n) begin
        if (!rx_areset_n) begin
            write_gray <= '0;
        end else begin
            write_gray <= to_gray(buffer_port.write_pointer);
        end
    end

    always_ff @(posedge tx_aclk or negedge tx_areset_n) begin
        if (!tx_areset_n) begin
            read_gray <= '0;
        end else begin
            read_gray <= to_gray(read_pointer);
        end
    end

    // Write pointer into tx_aclk.
    always_ff @(posedge tx_aclk or negedge tx_areset_n) begin
        if (!tx_areset_n) begin
            for (int i = 0; i < stages; i++) begin
                write_gray_sync[i] <= '0;
            end
        end else begin
            write_gray_sync[0] <= write_gray; // First stage may go metastable.
            for (int i = 1; i < stages; i++) begin
                write_gray_sync[i] <= write_gray_sync[i - 1];
            end
        end
    end

    // Read pointer into rx_aclk.
    always_ff @(posedge rx_aclk or negedge rx_areset_n) begin
        if (!rx_areset_n) begin
            for (int i = 0; i < stages; i++) begin
                read_gray_sync[i] <= '0;
            end
        end else begin
            read_gray_sync[0] <= read_gray;
            for (int i = 1; i < stages; i++) begin
                read_gray_sync[i] <= read_gray_sync[i - 1];
            end
        end
    end

    always_comb begin
        write_pointer_synced            = to_binary(write_gray_sync[stages - 1]);
        buffer_port.read_pointer_synced = to_binary(read_gray_sync[stages - 1]);
    end

    // A safe crossing depends on the captured value differing by at most one bit.
    write_gray_one_bit: assert property (@(posedge rx_aclk) disable iff (!rx_areset_n)
        $countones(write_gray ^ $past(write_gray)) <= 1)
        else $error("Gray write pointer changed more than one bit in one edge.");

endmodule

`default_nettype wire

//--- hdl/cdc_fifo_read.sv
// Read side of the dual-clock FIFO; drives the registered tx stream under back-pressure.
`timescale 1ns/100ps
`default_nettype none

module cdc_fifo_read (
    input  logic                       tx_aclk,
    input  logic                       tx_areset_n,
    input  cdc_fifo_pkg::cdc_data_t    read_data,
    input  cdc_fifo_pkg::cdc_pointer_t write_pointer_synced,
    output cdc_fifo_pkg::cdc_pointer_t read_pointer,
    output logic                       tx_tvalid,
    output cdc_fifo_pkg::cdc_data_t    tx_tdata,
    input  logic                       tx_tready
);
    import cdc_fifo_pkg::*;

    cdc_pointer_t read_pointer_next; // Address of the entry after the current one.
    logic         not_empty;         // At least one unread word in the array.
    logic         output_free;       // Output register is empty or being taken.
    logic         load;              // Move one word from the array to the output.

    // Equal pointers mean empty. The write side never lets them become equal when full.
    always_comb begin
        not_empty         = (write_pointer_synced != read_pointer);
        output_free       = !tx_tvalid || tx_tready;
        load              = not_empty && output_free;
        read_pointer_next = read_pointer + 1'b1;
    end

    always_ff @(posedge tx_aclk or negedge tx_areset_n) begin
        if (!tx_areset_n) begin
            read_pointer <= '0;
        end else if (load) begin
            read_pointer <= read_pointer_next; // Frees the entry for the write side.
        end
    end

    // Valid stays up across back-to-back loads and clears only when the last word is taken.
    always_ff @(posedge tx_aclk or negedge tx_areset_n) begin
        if (!tx_areset_n) begin
            tx_tvalid <= 1'b0;
        end else if (load) begin
            tx_tvalid <= 1'b1;
        end else if (tx_tready) begin
            tx_tvalid <= 1'b0;
        end
    end

    always_ff @(posedge tx_aclk) begin
        if (load) begin
            tx_tdata <= read_data; // Held otherwise, as the stream rule requires.
        end
    end

    // A stalled word must stay on the bus unchanged until the receiver takes it.
    tx_stable_while_stalled: assert property (@(posedge tx_aclk) disable iff (!tx_areset_n)
        (tx_tvalid && !tx_tready) |=> ($stable(tx_tvalid) && $stable(tx_tdata)))
        else $error("tx stream changed while stalled.");

endmodule

`default_nettype wire

//--- hdl/cdc_fifo.sv
// Top level of the dual-clock FIFO; connects the write side, buffer and read side to plain ports.
`timescale 1ns/100ps
`default_nettype none

module cdc_fifo (
    // rx_aclk domain.
    input  logic                    rx_aclk,
    input  logic                    rx_areset_n,
    input  logic                    rx_tvalid,
    input  cdc_fifo_pkg::cdc_data_t rx_tdata,
    output logic                    rx_tready,
    // tx_aclk domain.
    input  logic                    tx_aclk,
    input  logic                    tx_areset_n,
    output logic                    tx_tvalid,
    output cdc_fifo_pkg::cdc_data_t tx_tdata,
    input  logic                    tx_tready
);
    import cdc_fifo_pkg::*;

    cdc_pointer_t read_pointer;         // From the read side to the buffer.
    cdc_data_t    read_data;            // Entry at read_pointer.
    cdc_pointer_t write_pointer_synced; // Write pointer after the crossing into tx_aclk.

    // Write path, entirely in rx_aclk.
    cdc_fifo_write_if u_write_if ();

    cdc_fifo_write u_write (
        .rx_aclk     (rx_aclk),
        .rx_areset_n (rx_areset_n),
        .rx_tvalid   (rx_tvalid),
        .rx_tdata    (rx_tdata),
        .rx_tready   (rx_tready),
        .write_port  (u_write_if.write)
    );

    // The only block that sees both clocks.
    cdc_fifo_buffer u_buffer (
        .rx_aclk              (rx_aclk),
        .rx_areset_n          (rx_areset_n),
        .tx_aclk              (tx_aclk),
        .tx_areset_n          (tx_areset_n),
        .buffer_port          (u_write_if.buffer),
        .read_pointer         (read_pointer),
        .read_data            (read_data),
        .write_pointer_synced (write_pointer_synced)
    );

    cdc_fifo_read u_read (
        .tx_aclk              (tx_aclk),
        .tx_areset_n          (tx_areset_n),
        .read_data            (read_data),
        .write_pointer_synced (write_pointer_synced),
        .read_pointer         (read_pointer),
        .tx_tvalid            (tx_tvalid),
        .tx_tdata             (tx_tdata),
        .tx_tready            (tx_tready)
    );

endmodule

`default_nettype wire

//--- test/cdc_fifo_tb.sv
// Self-checking testbench that streams random words through the dual-clock FIFO and checks their order.
`include "cdc_fifo_macros.svh"
`timescale 1ns/100ps
`default_nettype none

module cdc_fifo_tb;
    import cdc_fifo_pkg::*;

    localparam int depth         = 1 << `CDC_FIFO_ADDRESS_WIDTH; // Entries in the array.
    localparam int send_timeout  = 200;  // Rx cycles allowed for one word to be taken.
    localparam int stall_limit   = 20;   // Rx cycles of low ready that count as throttled.
    localparam int drain_timeout = 3000; // Tx cycles allowed for the FIFO to empty.
    localparam int tx_free       = 0;    // The receiver is always ready.
    localparam int tx_stall      = 1;    // The receiver refuses every word.
    localparam int tx_random     = 2;    // The receiver is ready three cycles out of four.
    localparam int stream_words  = 200;  // Words sent back to back with a free receiver.
    localparam int stall_words   = 40;   // Words offered around the stalled receiver.
    localparam int gap_words     = 300;  // Words sent with random gaps on both sides.

    logic      rx_aclk = 1'b0;
    logic      rx_areset_n;
    logic      rx_tvalid;
    cdc_data_t rx_tdata;
    logic      rx_tready;
    logic      tx_aclk = 1'b0;
    logic      tx_areset_n;
    logic      tx_tvalid;
    cdc_data_t tx_tdata;
    logic      tx_tready;

    cdc_data_t expected_queue [$];  // Words taken on rx and not yet seen on tx.
    string     test_name = "reset";
    int        tx_mode = tx_free;
    int        received_count = 0;  // Words delivered on tx since the start.
    logic      was_stalled = 1'b0;  // The tx stream was stalled at the previous tx edge.
    cdc_data_t held_data;           // The tx word seen at the previous tx edge.

    cdc_fifo u_dut (
        .rx_aclk     (rx_aclk),
        .rx_areset_n (rx_areset_n),
        .rx_tvalid   (rx_tvalid),
        .rx_tdata    (rx_tdata),
        .rx_tready   (rx_tready),
        .tx_aclk     (tx_aclk),
        .tx_areset_n (tx_areset_n),
        .tx_tvalid   (tx_tvalid),
        .tx_tdata    (tx_tdata),
        .tx_tready   (tx_tready)
    );

    always #20 rx_aclk = ~rx_aclk; // 40 ns period.
    always #28 tx_aclk = ~tx_aclk; // 56 ns period, so the two edges drift against each other.

    // Under first-in-first-out order the next word out is the oldest word taken in.
    function automatic cdc_data_t cdc_fifo_expected();
        return expected_queue[0];
    endfunction

    task automatic print_failure(input string reason);
        $display("%s", reason);
        $display("** FAIL **");
    endtask

    // Every rx transfer is recorded as it happens.
    always @(posedge rx_aclk) begin
        if (rx_areset_n && rx_tvalid && rx_tready) begin
            expected_queue.push_back(rx_tdata);
        end
    end

    always @(negedge tx_aclk) begin
        case (tx_mode)
            tx_stall:  tx_tready = 1'b0;
            tx_random: tx_tready = ($urandom % 4) != 0;
            default:   tx_tready = 1'b1;
        endcase
    end

    always @(posedge tx_aclk) begin : compare_tx
        cdc_data_t expected_word;
        if (tx_areset_n) begin
            // A stalled word has to be on the bus unchanged one edge later.
            if (was_stalled) begin
                assert (tx_tvalid) else begin
                    print_failure($sformatf("ERR %s expected %h actual %h", test_name, 1'b1,
                        tx_tvalid));
                    $fatal(1, "Simulation stopped at the first failure.");
                end
                assert (tx_tdata == held_data) else begin
                    print_failure($sformatf("ERR %s expected %h actual %h", test_name,
                        held_data, tx_tdata));
                    $fatal(1, "Simulation stopped at the first failure.");
                end
            end
            if (tx_tvalid && tx_tready) begin
                assert (expected_queue.size() > 0) else begin
                    print_failure("A word came out on tx that was never taken on rx.");
                    $fatal(1, "Simulation stopped at the first failure.");
                end
                expected_word = cdc_fifo_expected();
                assert (tx_tdata == expected_word) else begin
                    print_failure($sformatf("ERR %s expected %h actual %h", test_name,
                        expected_word, tx_tdata));
                    $fatal(1, "Simulation stopped at the first failure.");
                end
                void'(expected_queue.pop_front());
                received_count++;
            end
            was_stalled = tx_tvalid && !tx_tready;
            held_data   = tx_tdata;
        end else begin
            was_stalled = 1'b0;
        end
    end

    initial begin : tx_reset
        tx_areset_n = 1'b0;
        repeat (5) @(negedge tx_aclk);
        tx_areset_n = 1'b1;
    end

    // Called at an rx falling edge. Returns at the next falling edge after the transfer,
    // or after the limit with valid still high and the word still offered.
    task automatic offer_word(input cdc_data_t word, input int limit, output bit accepted);
        int waited;
        waited    = 0;
        rx_tvalid = 1'b1;
        rx_tdata  = word;
        while (!rx_tready && waited < limit) begin
            @(negedge rx_aclk);
            waited++;
        end
        accepted = rx_tready;
        if (accepted) begin
            @(negedge rx_aclk); // The word moves at the rising edge in between.
        end
    endtask

    task automatic send_word(input cdc_data_t word);
        bit accepted;
        offer_word(word, send_timeout, accepted);
        assert (accepted) else begin
            print_failure($sformatf("Timed out in %s waiting for rx_tready.", test_name));
            $fatal(1, "Simulation stopped at the first failure.");
        end
    endtask

    task automatic send_random_words(input int count, input bit with_gaps);
        int gap;
        for (int i = 0; i < count; i++) begin
            if (with_gaps && ($urandom % 3) == 0) begin
                rx_tvalid = 1'b0; // Only dropped between transfers.
                gap = 1 + ($urandom % 3);
                repeat (gap) @(negedge rx_aclk);
            end
            send_word(cdc_data_t'($urandom));
        end
        rx_tvalid = 1'b0;
    endtask

    // Empty means every taken word has come out and the output register is clear.
    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while (expected_queue.size() != 0 || tx_tvalid) begin
            @(negedge tx_aclk);
            waited++;
            assert (waited < drain_timeout) else begin
                print_failure($sformatf("Timed out in %s waiting for the FIFO to drain.",
                    test_name));
                $fatal(1, "Simulation stopped at the first failure.");
            end
        end
        @(negedge rx_aclk); // Back to the rx drive point.
    endtask

    initial begin : main_sequence
        bit        accepted;
        int        taken;
        int        waited;
        int        in_array;
        cdc_data_t pending;
        void'($urandom(32'h6f1b_9762));
        rx_areset_n = 1'b0;
        rx_tvalid   = 1'b0;
        rx_tdata    = '0;
        tx_tready   = 1'b0;

        // Both outputs stay low for the whole rx reset.
        for (int i = 0; i < 5; i++) begin
            @(negedge rx_aclk);
            assert (!rx_tready && !tx_tvalid) else begin
                print_failure("rx_tready or tx_tvalid was high during reset.");
                $fatal(1, "Simulation stopped at the first failure.");
            end
        end
        rx_areset_n = 1'b1;
        waited = 0;
        while (!rx_tready || !tx_areset_n) begin
            @(negedge rx_aclk);
            waited++;
            assert (waited < 10) else begin
                print_failure("rx_tready did not rise after reset was released.");
                $fatal(1, "Simulation stopped at the first failure.");
            end
        end

        test_name = "streaming";
        send_random_words(stream_words, 1'b0);
        wait_for_drain();

        test_name = "backpressure";
        tx_mode   = tx_stall;
        repeat (2) @(negedge tx_aclk); // The stall is driven at the first tx falling edge.
        @(negedge rx_aclk);
        taken    = 0;
        accepted = 1'b1;
        while (taken < stall_words && accepted) begin
            pending = cdc_data_t'($urandom);
            offer_word(pending, stall_limit, accepted);
            if (accepted) begin
                taken++;
            end
        end
        assert (!accepted) else begin
            print_failure("rx_tready stayed high while the receiver was stalled.");
            $fatal(1, "Simulation stopped at the first failure.");
        end
        // One taken word may already sit in the tx output register.
        in_array = expected_queue.size() - (tx_tvalid ? 1 : 0);
        assert (in_array < depth) else begin
            print_failure($sformatf("ERR %s expected below %0d actual %0d", test_name,
                depth, in_array));
            $fatal(1, "Simulation stopped at the first failure.");
        end
        tx_mode = tx_free;
        send_word(pending); // Still on the bus from the stalled offer.
        taken++;
        send_random_words(stall_words - taken, 1'b0);
        wait_for_drain();

        test_name = "random_gaps";
        tx_mode   = tx_random;
        send_random_words(gap_words, 1'b1);

        test_name = "drain";
        wait_for_drain();
        tx_mode = tx_free;
        for (int i = 0; i < 8; i++) begin
            @(negedge tx_aclk);
            assert (!tx_tvalid) else begin
                print_failure("tx_tvalid rose again after the FIFO had drained.");
                $fatal(1, "Simulation stopped at the first failure.");
            end
        end
        // Each word sent is delivered exactly once, so a repeated rx transfer shows up here.
        assert (received_count == stream_words + stall_words + gap_words) else begin
            print_failure($sformatf("ERR %s expected %0d actual %0d", test_name,
                stream_words + stall_words + gap_words, received_count));
            $fatal(1, "Simulation stopped at the first failure.");
        end
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+hdl
hdl/cdc_fifo_pkg.sv
hdl/cdc_fifo_write_if.sv
hdl/cdc_fifo_write.sv
hdl/cdc_fifo_buffer.sv
hdl/cdc_fifo_read.sv
hdl/cdc_fifo.sv
test/cdc_fifo_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compiles the dual-clock FIFO and its testbench with Verilator and runs the simulation.
# The exit status is 0 only when the simulation prints the pass line.

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Cannot change to the project root."
    exit 1
fi

command -v verilator > /dev/null 2>&1
if [ $? -ne 0 ]; then
    echo "verilator was not found on the PATH."
    exit 1
fi

verilator --binary --timing --assert -j 0 \
    --top-module cdc_fifo_tb -Mdir obj_dir -f build.f
if [ $? -ne 0 ]; then
    echo "Compilation failed."
    exit 1
fi

sim_output=$(./obj_dir/Vcdc_fifo_tb 2>&1)
sim_status=$?
printf '%s\n' "$sim_output"

printf '%s\n' "$sim_output" | grep -qx '\*\* PASS \*\*'
if [ $? -eq 0 ]; then
    exit 0
fi

echo "Simulation did not pass, exit status ${sim_status}."
exit 1
